// File: compile.f
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core.sv
verification/rv_bus_checker.sv
verification/rv_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module rv_tb -o rv_sim

status=0
./obj_dir/rv_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
	exit 1
fi

// File: verification/rv_tb.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_tb import rv_pkg::*; ();

	localparam word_t halt_pc = 32'h0000_02fc; // Word 191

	logic     clk = 1'b0;
	logic     rst;
	bus_req_t bus_req;
	word_t    bus_rdata;
	logic     bus_ready;

	int    seed;
	int    wait_left = -1;
	int    value_errors = 0;
	int    other_errors = 0;
	int    n_writes = 0;
	int    n_model_writes;
	int    cycles;
	logic  halt_seen = 1'b0;
	word_t mem [0:1023];
	word_t model_mem [0:1023];
	word_t model_x [0:31];
	word_t exp_pc [$];    // PC trace of the model
	word_t exp_waddr [$];
	lane_t exp_wlane [$];
	word_t exp_wdata [$]; // Enabled bytes only

	rv_core rv_core_i (
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

	always #10 clk = ~clk;

	assign bus_rdata = mem[bus_req.addr[11:2]];

	////////////////////////////////////////
	// Random helpers and encoders
	////////////////////////////////////////

	function automatic int rnd(input int n);
		int v;
		v = $random(seed) & 32'h7fff_ffff;
		return v % n;
	endfunction

	function automatic reg_idx_t src_reg();
		return reg_idx_t'(rnd(8)); // x0 to x7
	endfunction

	function automatic reg_idx_t dest_reg();
		return reg_idx_t'(1 + rnd(7));
	endfunction

	function automatic word_t lane_mask(input lane_t l);
		return {{8{l[3]}}, {8{l[2]}}, {8{l[1]}}, {8{l[0]}}};
	endfunction

	// Also builds R format with func7 and rs2 in imm
	function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [4:0] opc);
		return {imm, rs1, f3, rd, opc, 2'b11};
	endfunction

	function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE, 2'b11};
	endfunction

	function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH, 2'b11};
	endfunction

	function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, logic [4:0] opc);
		return {imm, rd, opc, 2'b11};
	endfunction

	function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL, 2'b11};
	endfunction

	function automatic word_t random_alu();
		logic [2:0]  f3;
		logic [11:0] imm;
		logic        alt;
		f3  = 3'(rnd(8));
		imm = 12'(rnd(4096));
		alt = (f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1; // sub or sra
		if (f3 == 3'b001 || f3 == 3'b101)
			imm = {1'b0, alt, 5'b0, imm[4:0]};
		if (rnd(2) == 1)
			return i_type({1'b0, alt, 5'b0, src_reg()}, src_reg(), f3, dest_reg(), `RV_OPC_OP);
		return i_type(imm, src_reg(), f3, dest_reg(), `RV_OPC_OP_IMM);
	endfunction

	task automatic build_program();
		int         idx;
		int         kind;
		word_t      ea;
		logic [2:0] f3;
		for (int i = 0; i < 1024; i++)
			mem[i] = word_t'(i) * 32'h9e37_79b1 + 32'h0f1e_2d3c;
		idx = 0;
		while (idx < 184)
		begin
			kind = rnd(10);
			if (kind >= 7 && idx > 182)
				kind = 0; // No room for a skipped word
			case (kind)
				4: mem[idx] = u_type(20'(rnd(1 << 20)), dest_reg(),
					rnd(2) == 1 ? `RV_OPC_LUI : `RV_OPC_AUIPC);
				5:
				begin
					f3 = 3'(rnd(3));
					ea = (32'h400 + word_t'(rnd(1024))) & ~((32'd1 << f3) - 32'd1);
					mem[idx] = s_type(ea[11:0], src_reg(), 5'd0, f3);
				end
				6:
				begin
					f3 = 3'(rnd(5));
					if (f3 >= 3'd3)
						f3 = f3 + 3'd1; // LBU and LHU
					ea = (32'h400 + word_t'(rnd(1024))) & ~((32'd1 << f3[1:0]) - 32'd1);
					mem[idx] = i_type(ea[11:0], 5'd0, f3, dest_reg(), `RV_OPC_LOAD);
				end
				7:
				begin
					f3 = 3'(rnd(4));
					if (f3 == 3'd2)
						f3 = 3'd4;
					else if (f3 == 3'd3)
						f3 = 3'd7;
					mem[idx] = b_type(13'd8, src_reg(), src_reg(), f3);
					mem[idx + 1] = random_alu();
					idx++;
				end
				8:
				begin
					if (rnd(2) == 1)
						mem[idx] = j_type(21'd8, dest_reg());
					else
						mem[idx] = i_type(12'(idx * 4 + 8), 5'd0, 3'b000, dest_reg(), `RV_OPC_JALR);
					mem[idx + 1] = random_alu();
					idx++;
				end
				default: mem[idx] = random_alu();
			endcase
			idx++;
		end
		for (int r = 1; r < 8; r++)
			mem[183 + r] = s_type(12'(32'h7e0 + 4 * r), reg_idx_t'(r), 5'd0, 3'b010);
		mem[191] = j_type(21'd0, 5'd0); // Jump to itself
		for (int i = 0; i < 1024; i++)
			model_mem[i] = mem[i];
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return word_t'($signed(a) < $signed(b));
			3'b011:  return word_t'(a < b);
			3'b100:  return a ^ b;
			3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic run_model();
		word_t      pc;
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      ea;
		word_t      w;
		word_t      res;
		word_t      nxt;
		word_t      imm_i;
		word_t      mask;
		lane_t      ln;
		logic [2:0] f3;
		logic       wr_rd;
		for (int i = 0; i < 32; i++)
			model_x[i] = '0;
		pc = `RV_RESET_PC;
		for (int steps = 0; steps < 4000; steps++)
		begin
			exp_pc.push_back(pc);
			if (pc == halt_pc)
				break;
			ins   = model_mem[pc[11:2]];
			f3    = ins[14:12];
			a     = model_x[ins[19:15]];
			b     = model_x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			nxt   = pc + 4;
			res   = pc + 4; // Link value for jumps
			wr_rd = 1'b1;
			case (ins[6:2])
				`RV_OPC_OP:     res = alu_model(f3, ins[30], a, b);
				`RV_OPC_OP_IMM: res = alu_model(f3, ins[30] && f3 == 3'b101, a, imm_i);
				`RV_OPC_LUI:    res = {ins[31:12], 12'b0};
				`RV_OPC_AUIPC:  res = pc + {ins[31:12], 12'b0};
				`RV_OPC_JAL:    nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				`RV_OPC_JALR:   nxt = (a + imm_i) & ~32'h1;
				`RV_OPC_BRANCH:
				begin
					wr_rd = 1'b0;
					if (branch_model(f3, a, b))
						nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				`RV_OPC_LOAD:
				begin
					ea = a + imm_i;
					w  = model_mem[ea[11:2]] >> {ea[1:0], 3'b000};
					case (f3)
						3'b000:  res = {{24{w[7]}}, w[7:0]};
						3'b001:  res = {{16{w[15]}}, w[15:0]};
						3'b100:  res = {24'b0, w[7:0]};
						3'b101:  res = {16'b0, w[15:0]};
						default: res = w;
					endcase
				end
				`RV_OPC_STORE:
				begin
					wr_rd = 1'b0;
					ea    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					ln    = lane_t'(((1 << (1 << f3[1:0])) - 1) << ea[1:0]); // Size in bytes
					w     = b << {ea[1:0], 3'b000}; // Value moved onto its lanes
					mask  = lane_mask(ln);
					model_mem[ea[11:2]] = (model_mem[ea[11:2]] & ~mask) | (w & mask);
					exp_waddr.push_back({ea[31:2], 2'b00});
					exp_wlane.push_back(ln);
					exp_wdata.push_back(w & mask);
				end
				default: wr_rd = 1'b0;
			endcase
			if (wr_rd && ins[11:7] != 5'd0)
				model_x[ins[11:7]] = res;
			pc = nxt;
		end
		n_model_writes = exp_waddr.size();
	endtask

	////////////////////////////////////////
	// Bus memory and checks
	////////////////////////////////////////

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic take_write();
		word_t mask;
		lane_t el;
		mask = lane_mask(bus_req.lane);
		mem[bus_req.addr[11:2]] = (mem[bus_req.addr[11:2]] & ~mask) | (bus_req.wdata & mask);
		n_writes++;
		assert (exp_waddr.size() > 0)
		begin
			el = exp_wlane.pop_front();
			compare_word("bus_req.addr", bus_req.addr, exp_waddr.pop_front());
			compare_word("bus_req.lane", {28'b0, bus_req.lane}, {28'b0, el});
			compare_word("bus_req.wdata", bus_req.wdata & lane_mask(el), exp_wdata.pop_front());
		end
		else
		begin
			other_errors++;
			$display("Bus write to %h that the model does not expect", bus_req.addr);
		end
	endtask

	task automatic take_fetch();
		if (halt_seen)
			return; // Halt loop keeps fetching
		assert (exp_pc.size() > 0)
		begin
			compare_word("fetch bus_req.addr", bus_req.addr, exp_pc.pop_front());
		end
		else
		begin
			other_errors++;
			$display("Fetch past the end of the model's instruction trace");
		end
		if (bus_req.addr == halt_pc)
			halt_seen = 1'b1;
	endtask

	// Transfer completes on the coming rising edge
	always @(negedge clk)
	begin
		if (!rst && bus_req.valid && bus_ready)
		begin
			if (bus_req.wr)
				take_write();
			else if (bus_req.addr < 32'h400)
				take_fetch();
		end
	end

	// Ready after 0 to 3 wait cycles
	always @(posedge clk)
	begin
		#1;
		if (rst || bus_ready)
			bus_ready = 1'b0;
		else if (bus_req.valid)
		begin
			if (wait_left < 0)
				wait_left = rnd(4);
			if (wait_left == 0)
				bus_ready = 1'b1;
			wait_left--;
		end
	end

	initial
	begin
		seed      = 32'he84b_e087;
		rst       = 1'b1;
		bus_ready = 1'b0;
		build_program();
		run_model();
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		cycles = 0;
		while (!bus_req.valid && cycles < 50)
		begin
			@(posedge clk);
			#1 cycles++;
		end
		assert (bus_req.valid)
		begin
			compare_word("bus_req.addr", bus_req.addr, `RV_RESET_PC);
			compare_word("bus_req.lane", {28'b0, bus_req.lane}, 32'hf);
			compare_word("bus_req.wr", {31'b0, bus_req.wr}, 32'h0);
		end
		else
		begin
			other_errors++;
			$display("No bus request after reset");
		end

		cycles = 0;
		while (!halt_seen && cycles < 20000)
		begin
			@(posedge clk);
			cycles++;
		end
		assert (halt_seen)
		else
		begin
			other_errors++;
			$display("Halt address never fetched");
		end
		compare_word("bus write count", n_writes, n_model_writes);
		other_errors += rv_core_i.bus_checker_i.failures; // Bus protocol assertions

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: verification/rv_bus_checker.sv
`timescale 1ns/1ps

module rv_bus_checker import rv_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input bus_req_t bus_req,
	input logic     bus_ready
);

	int failures = 0;

	// Nothing pending on the first edge out of reset
	valid_after_reset: assert property (@(posedge clk) $fell(rst) |-> !bus_req.valid)
		else
		begin
			failures++;
			$error("bus request valid right after reset");
		end

	// Request held until ready
	req_stable: assert property (@(posedge clk) disable iff (rst)
		bus_req.valid && !bus_ready |=> bus_req.valid && $stable(bus_req.addr)
			&& $stable(bus_req.wr) && $stable(bus_req.lane) && $stable(bus_req.wdata))
		else
		begin
			failures++;
			$error("bus request changed while waiting for ready");
		end

	write_has_lanes: assert property (@(posedge clk) disable iff (rst)
		bus_req.valid && bus_req.wr |-> bus_req.lane != '0)
		else
		begin
			failures++;
			$error("bus write with no byte lane enabled");
		end

endmodule

bind rv_core rv_bus_checker bus_checker_i (
	.clk       (clk),
	.rst       (rst),
	.bus_req   (bus_req),
	.bus_ready (bus_ready)
);

// File: design/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core import rv_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output bus_req_t bus_req,
	input  word_t    bus_rdata,
	input  logic     bus_ready
);

	state_e   state;
	addr_t    pc;        // Next fetch address
	addr_t    instr_pc;  // Address of the instruction in ir
	word_t    ir;
	decoded_t dec;

	word_t op_a;
	word_t op_b;
	word_t store_val;
	word_t result;       // Value for rd

	word_t rf_a;
	word_t rf_b;
	logic  rf_we;
	word_t alu_result;
	logic  taken;
	lane_t lsu_lane;
	word_t lsu_wdata;
	word_t load_val;

	////////////////////////////////////////
	// Datapath blocks
	////////////////////////////////////////

	rv_decode decode_i (
		.instr (ir),
		.dec   (dec)
	);

	rv_regfile regfile_i (
		.clk       (clk),
		.rst       (rst),
		.rd_idx_a  (dec.rs1),
		.rd_idx_b  (dec.rs2),
		.rd_data_a (rf_a),
		.rd_data_b (rf_b),
		.wr_en     (rf_we),
		.wr_idx    (dec.rd),
		.wr_data   (result)
	);

	rv_alu alu_i (
		.alu_op (dec.alu_op),
		.func3  (dec.func3),
		.a      (op_a),
		.b      (op_b),
		.result (alu_result),
		.taken  (taken)
	);

	rv_lsu lsu_i (
		.func3     (dec.func3),
		.byte_addr (alu_result), // Operands held through mem
		.store_val (store_val),
		.rdata     (bus_rdata),
		.lane      (lsu_lane),
		.wdata     (lsu_wdata),
		.load_val  (load_val)
	);

	assign rf_we = (state == st_writeback) && dec.writes_rd;

	////////////////////////////////////////
	// Control FSM and bus driver
	////////////////////////////////////////

	// Starts in writeback so the first fetch is issued from there
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state    <= st_writeback;
			pc       <= `RV_RESET_PC;
			instr_pc <= `RV_RESET_PC;
			ir       <= '0; // Decodes with writes_rd low
			bus_req  <= '0;
		end
		else
		begin
			case (state)
				st_fetch:
				if (bus_ready)
				begin
					ir            <= bus_rdata;
					instr_pc      <= pc;
					pc            <= pc + 32'd4;
					bus_req.valid <= 1'b0;
					state         <= st_decode;
				end
				st_decode:
					state <= st_execute;
				st_execute:
				begin
					state <= st_writeback;
					case (dec.op_class)
						cls_jal:  pc <= instr_pc + dec.imm;
						cls_jalr: pc <= {alu_result[`RV_XLEN-1:1], 1'b0};
						cls_branch:
						if (taken)
							pc <= instr_pc + dec.imm;
						cls_load, cls_store:
						begin
							bus_req.addr  <= {alu_result[`RV_XLEN-1:2], 2'b00};
							bus_req.wdata <= lsu_wdata;
							bus_req.wr    <= (dec.op_class == cls_store);
							bus_req.lane  <= lsu_lane;
							bus_req.valid <= 1'b1;
							state         <= st_mem;
						end
						default: ;
					endcase
				end
				st_mem:
				if (bus_ready)
				begin
					bus_req.valid <= 1'b0;
					bus_req.wr    <= 1'b0;
					state         <= st_writeback;
				end
				default: // Writeback, then request the next instruction
				begin
					bus_req.addr  <= pc;
					bus_req.wr    <= 1'b0;
					bus_req.lane  <= 4'b1111;
					bus_req.valid <= 1'b1;
					state         <= st_fetch;
				end
			endcase
		end
	end

	// Operand and result registers
	always_ff @(posedge clk)
	begin
		case (state)
			st_decode:
			begin
				op_a      <= rf_a;
				op_b      <= dec.use_imm ? dec.imm : rf_b;
				store_val <= rf_b;
			end
			st_execute:
			case (dec.op_class)
				cls_lui:           result <= dec.imm;
				cls_auipc:         result <= instr_pc + dec.imm;
				cls_jal, cls_jalr: result <= pc; // Link address, pc is instr_pc + 4 here
				default:           result <= alu_result;
			endcase
			st_mem:
			if (bus_ready && !bus_req.wr)
				result <= load_val;
			default: ;
		endcase
	end

endmodule

// File: design/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_lsu import rv_pkg::*;
(
	input  logic [2:0] func3,
	input  addr_t      byte_addr,
	input  word_t      store_val,
	input  word_t      rdata,
	output lane_t      lane,
	output word_t      wdata,
	output word_t      load_val
);

	logic [1:0] size;
	logic [1:0] offs;
	logic       unsigned_ld;
	word_t      shifted;

	assign size        = func3[1:0]; // 0 byte, 1 half, 2 word
	assign offs        = byte_addr[1:0];
	assign unsigned_ld = func3[2];

	////////////////////////////////////////
	// Store side
	////////////////////////////////////////

	always_comb
	begin
		case (size)
			2'b00:
			begin
				wdata = {4{store_val[7:0]}};
				lane  = lane_t'(4'b0001 << offs);
			end
			2'b01:
			begin
				wdata = {2{store_val[15:0]}};
				lane  = offs[1] ? 4'b1100 : 4'b0011;
			end
			default:
			begin
				wdata = store_val;
				lane  = 4'b1111;
			end
		endcase
	end

	////////////////////////////////////////
	// Load side
	////////////////////////////////////////

	assign shifted = rdata >> {offs, 3'b000}; // Addressed byte lands in bits 7:0

	always_comb
	begin
		case (size)
			2'b00:   load_val = {{(`RV_XLEN-8){shifted[7] & !unsigned_ld}}, shifted[7:0]};
			2'b01:   load_val = {{(`RV_XLEN-16){shifted[15] & !unsigned_ld}}, shifted[15:0]};
			default: load_val = rdata;
		endcase
	end

endmodule

// File: design/rv_alu.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu import rv_pkg::*;
(
	input  alu_op_e    alu_op,
	input  logic [2:0] func3,
	input  word_t      a,
	input  word_t      b,
	output word_t      result,
	output logic       taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb
	begin
		case (alu_op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
			alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
			alu_sll:  result = a << shamt;
			alu_srl:  result = a >> shamt;
			alu_sra:  result = word_t'($signed(a) >>> shamt); // Barrel shift, one cycle
			default:  result = a + b;
		endcase
	end

	// Branch condition
	always_comb
	begin
		case (func3)
			3'b000:  taken = (a == b);
			3'b001:  taken = (a != b);
			3'b100:  taken = lt_s;
			3'b101:  taken = !lt_s;
			3'b110:  taken = lt_u;
			3'b111:  taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

endmodule

// File: design/rv_decode.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*;
(
	input  word_t    instr,
	output decoded_t dec
);

	logic [4:0] opcode;
	logic [2:0] func3;
	logic       func7_5;
	word_t      i_imm;
	word_t      s_imm;
	word_t      b_imm;
	word_t      u_imm;
	word_t      j_imm;
	alu_op_e    arith_op;

	assign opcode  = instr[6:2];
	assign func3   = instr[14:12];
	assign func7_5 = instr[30];

	////////////////////////////////////////
	// Immediate formats
	////////////////////////////////////////

	assign i_imm = {{20{instr[31]}}, instr[31:20]};
	assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'b0};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// Integer op from func3 with func7 bit 5 picking sub and sra
	always_comb
	begin
		case (func3)
			3'b000:  arith_op = (opcode == `RV_OPC_OP && func7_5) ? alu_sub : alu_add;
			3'b001:  arith_op = alu_sll;
			3'b010:  arith_op = alu_slt;
			3'b011:  arith_op = alu_sltu;
			3'b100:  arith_op = alu_xor;
			3'b101:  arith_op = func7_5 ? alu_sra : alu_srl;
			3'b110:  arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	always_comb
	begin
		dec          = '0;
		dec.func3    = func3;
		dec.rd       = instr[11:7];
		dec.rs1      = instr[19:15];
		dec.rs2      = instr[24:20];
		dec.op_class = cls_illegal;
		dec.alu_op   = alu_add; // Address arithmetic by default
		dec.imm      = i_imm;
		dec.use_imm  = 1'b0;
		case (opcode)
			`RV_OPC_OP:
			begin
				dec.op_class = cls_alu;
				dec.alu_op   = arith_op;
			end
			`RV_OPC_OP_IMM:
			begin
				dec.op_class = cls_alu;
				dec.alu_op   = arith_op;
				dec.use_imm  = 1'b1;
			end
			`RV_OPC_LUI:
			begin
				dec.op_class = cls_lui;
				dec.imm      = u_imm;
			end
			`RV_OPC_AUIPC:
			begin
				dec.op_class = cls_auipc;
				dec.imm      = u_imm;
			end
			`RV_OPC_JAL:
			begin
				dec.op_class = cls_jal;
				dec.imm      = j_imm;
			end
			`RV_OPC_JALR:
			begin
				dec.op_class = cls_jalr;
				dec.use_imm  = 1'b1;
			end
			`RV_OPC_BRANCH:
			begin
				dec.op_class = cls_branch;
				dec.imm      = b_imm;
			end
			`RV_OPC_LOAD:
			begin
				dec.op_class = cls_load;
				dec.use_imm  = 1'b1;
			end
			`RV_OPC_STORE:
			begin
				dec.op_class = cls_store;
				dec.imm      = s_imm;
				dec.use_imm  = 1'b1;
			end
			default:        dec.op_class = cls_illegal; // Runs as a no-op
		endcase
		dec.writes_rd = (dec.rd != '0) && !(dec.op_class inside
			{cls_branch, cls_store, cls_illegal});
	end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile import rv_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t regs [1:`RV_REG_COUNT-1]; // No storage behind x0

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 1; i < `RV_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_idx != '0)
			regs[wr_idx] <= wr_data;
	end

	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

// File: design/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_XLEN-1:0] addr_t;
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;
	typedef logic [3:0] lane_t; // One bit per byte

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef enum logic [3:0] {
		cls_alu, cls_lui, cls_auipc, cls_jal, cls_jalr,
		cls_branch, cls_load, cls_store, cls_illegal
	} op_class_e;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_mem, st_writeback
	} state_e;

	typedef struct packed {
		op_class_e op_class;
		alu_op_e   alu_op;
		logic [2:0] func3;     // Branch condition or access size
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		word_t     imm;        // Sign-extended already
		logic      use_imm;
		logic      writes_rd;
	} decoded_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  wr;
		lane_t lane;
		logic  valid;
	} bus_req_t;

endpackage

// File: design/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and register file sizing
`define RV_XLEN       32
`define RV_REG_COUNT  32
`define RV_RESET_PC   32'h0000_0000

// Major opcodes, instr[6:2]
`define RV_OPC_LOAD   5'b00000
`define RV_OPC_STORE  5'b01000
`define RV_OPC_OP     5'b01100
`define RV_OPC_OP_IMM 5'b00100
`define RV_OPC_LUI    5'b01101
`define RV_OPC_AUIPC  5'b00101
`define RV_OPC_JAL    5'b11011
`define RV_OPC_JALR   5'b11001
`define RV_OPC_BRANCH 5'b11000

`endif
